// File: axil_fork_regs.sv
`timescale 1ns/10ps

module axil_fork_regs (
	input logic clk,
	input logic arst_n,

	input loop_pkg::axi_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input loop_pkg::axi_data_t wdata,
	input loop_pkg::axi_strb_t wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,

	input loop_pkg::axi_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output loop_pkg::axi_data_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,

	fork_cfg_if.regs cfg
);

	logic aw_accept;
	logic ar_accept;
	logic ctrl_start;
	loop_pkg::axi_addr_t aw_word;
	loop_pkg::axi_addr_t ar_word;
	loop_pkg::gc_t base_q;
	loop_pkg::gd_t stride_q;
	loop_pkg::cnt_t count_q;
	logic done_q;
	loop_pkg::axi_data_t rd_mux;

	function automatic logic is_mapped(input loop_pkg::axi_addr_t word);
		case (word)
			loop_pkg::REG_CTRL, loop_pkg::REG_STATUS, loop_pkg::REG_BASE,
			loop_pkg::REG_STRIDE, loop_pkg::REG_COUNT, loop_pkg::REG_REMAIN:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// Byte lanes with a strobe take the new data
	function automatic loop_pkg::axi_data_t merge_strb(
		input loop_pkg::axi_data_t old_val,
		input loop_pkg::axi_data_t new_val,
		input loop_pkg::axi_strb_t strb
	);
		loop_pkg::axi_data_t res;
		res = old_val;
		for (int b = 0; b < loop_pkg::AXI_STRB_WIDTH; b++) begin
			if (strb[b]) begin
				res[8*b +: 8] = new_val[8*b +: 8];
			end
		end
		return res;
	endfunction

	// Low address bits are ignored
	assign aw_word = {awaddr[loop_pkg::AXI_ADDR_WIDTH-1:2], 2'b00};
	assign ar_word = {araddr[loop_pkg::AXI_ADDR_WIDTH-1:2], 2'b00};

	// One write in flight at a time
	assign aw_accept = awvalid && wvalid && !bvalid;
	assign awready = aw_accept;
	assign wready = aw_accept;

	assign ar_accept = arvalid && !rvalid;
	assign arready = ar_accept;

	// Start only from idle; a start while busy is dropped silently
	assign ctrl_start = aw_accept && (aw_word == loop_pkg::REG_CTRL)
		&& wstrb[0] && wdata[0] && !cfg.busy;

	assign cfg.start = ctrl_start;
	assign cfg.base = base_q;
	assign cfg.stride = stride_q;
	assign cfg.count = count_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			base_q <= '0;
			stride_q <= '0;
			count_q <= '0;
		end else if (aw_accept) begin
			case (aw_word)
				loop_pkg::REG_BASE:
					base_q <= loop_pkg::gc_t'(merge_strb(base_q, wdata, wstrb));
				loop_pkg::REG_STRIDE:
					stride_q <= loop_pkg::gd_t'(merge_strb(stride_q, wdata, wstrb));
				loop_pkg::REG_COUNT:
					count_q <= loop_pkg::cnt_t'(merge_strb(
						loop_pkg::axi_data_t'(count_q), wdata, wstrb));
				default: ;
			endcase
		end
	end

	// Sticky done, cleared by the next start
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			done_q <= 1'b0;
		end else if (ctrl_start) begin
			done_q <= 1'b0;
		end else if (cfg.done_pulse) begin
			done_q <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (aw_accept) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			if (ar_accept) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_comb begin
		rd_mux = '0;
		case (ar_word)
			loop_pkg::REG_STATUS: rd_mux = {30'd0, done_q, cfg.busy};
			loop_pkg::REG_BASE:   rd_mux = base_q;
			loop_pkg::REG_STRIDE: rd_mux = stride_q;
			loop_pkg::REG_COUNT:  rd_mux = loop_pkg::axi_data_t'(count_q);
			loop_pkg::REG_REMAIN: rd_mux = loop_pkg::axi_data_t'(cfg.remain);
			default: ;
		endcase
	end

	// Response payload
	always_ff @(posedge clk) begin
		if (aw_accept) begin
			bresp <= is_mapped(aw_word) ? loop_pkg::AXI_RESP_OKAY : loop_pkg::AXI_RESP_SLVERR;
		end
		if (ar_accept) begin
			rdata <= rd_mux;
			rresp <= is_mapped(ar_word) ? loop_pkg::AXI_RESP_OKAY : loop_pkg::AXI_RESP_SLVERR;
		end
	end

endmodule

// File: fork_cfg_if.sv
`timescale 1ns/10ps

interface fork_cfg_if;

	// Loop setup from the register block
	logic start;
	loop_pkg::gc_t base;
	loop_pkg::gd_t stride;
	loop_pkg::cnt_t count;

	// Status back toward software
	logic busy;
	logic done_pulse;
	loop_pkg::cnt_t remain;

	modport regs (
		output start, base, stride, count,
		input busy, done_pulse, remain
	);

	modport ctrl (
		input start,
		output busy, done_pulse
	);

	modport alloc (
		input start, base, stride
	);

	modport cnt (
		input start, count,
		output remain
	);

endinterface

// File: fork_ctrl_fsm.sv
`timescale 1ns/10ps

module fork_ctrl_fsm (
	input logic clk,
	input logic arst_n,
	fork_cfg_if.ctrl cfg,
	input logic remain_zero,
	input loop_pkg::core_vec_t core_idle,
	output logic run
);

	loop_pkg::fork_state_t state;
	loop_pkg::fork_state_t state_next;
	logic all_idle;

	assign all_idle = &core_idle;

	always_comb begin
		state_next = state;
		case (state)
			loop_pkg::IDLE: begin
				if (cfg.start) begin
					state_next = loop_pkg::RUN;
				end
			end
			loop_pkg::RUN: begin
				// Last iteration issued
				if (remain_zero) begin
					state_next = loop_pkg::DRAIN;
				end
			end
			loop_pkg::DRAIN: begin
				// Wait for the cores to finish their work
				if (all_idle) begin
					state_next = loop_pkg::IDLE;
				end
			end
			default: begin
				state_next = loop_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= loop_pkg::IDLE;
		end else begin
			state <= state_next;
		end
	end

	assign run = (state == loop_pkg::RUN);
	assign cfg.busy = (state != loop_pkg::IDLE);

	// Single cycle, the one that leaves DRAIN
	assign cfg.done_pulse = (state == loop_pkg::DRAIN) && all_idle;

endmodule

// File: gc_allocator.sv
`timescale 1ns/10ps

module gc_allocator (
	input logic clk,
	input logic arst_n,
	fork_cfg_if.alloc cfg,
	input logic run,
	input logic remain_zero,
	input loop_pkg::cnt_t remain,
	input loop_pkg::core_vec_t gc_req,
	output loop_pkg::core_vec_t gc_grant,
	output loop_pkg::gc_t gc_out [loop_pkg::N_CORE],
	output loop_pkg::grant_cnt_t grant_cnt
);

	loop_pkg::gc_t gc_q;
	loop_pkg::gd_t gd_q;
	// Requests seen below each core
	loop_pkg::grant_cnt_t rank [loop_pkg::N_CORE+1];
	// Current index plus k strides
	loop_pkg::gc_t gc_plus [loop_pkg::N_CORE+1];
	logic issue_en;

	assign issue_en = run && !remain_zero;

	always_comb begin
		rank[0] = '0;
		for (int i = 0; i < loop_pkg::N_CORE; i++) begin
			rank[i+1] = rank[i] + loop_pkg::grant_cnt_t'(gc_req[i]);
		end
	end

	always_comb begin
		for (int k = 0; k <= loop_pkg::N_CORE; k++) begin
			gc_plus[k] = gc_q + loop_pkg::gc_t'(k) * gd_q;
		end
	end

	// Lowest requesters win, capped at remain
	always_comb begin
		grant_cnt = '0;
		for (int i = 0; i < loop_pkg::N_CORE; i++) begin
			gc_grant[i] = issue_en && gc_req[i] && (loop_pkg::cnt_t'(rank[i]) < remain);
			gc_out[i] = gc_plus[rank[i]];
			grant_cnt = grant_cnt + loop_pkg::grant_cnt_t'(gc_grant[i]);
		end
	end

	// Stride is latched so a register write mid-run has no effect
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			gc_q <= '0;
			gd_q <= '0;
		end else if (cfg.start) begin
			gc_q <= cfg.base;
			gd_q <= cfg.stride;
		end else begin
			gc_q <= gc_plus[grant_cnt];
		end
	end

endmodule

// File: iter_counter.sv
`timescale 1ns/10ps

module iter_counter (
	input logic clk,
	input logic arst_n,
	fork_cfg_if.cnt cfg,
	input logic run,
	input loop_pkg::grant_cnt_t grant_cnt,
	output logic remain_zero
);

	loop_pkg::cnt_t remain_q;

	// Iterations still to issue
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			remain_q <= '0;
		end else if (cfg.start) begin
			remain_q <= cfg.count;
		end else if (run) begin
			// Allocator never grants more than remain
			remain_q <= remain_q - loop_pkg::cnt_t'(grant_cnt);
		end
	end

	assign cfg.remain = remain_q;
	assign remain_zero = (remain_q == '0);

endmodule

// File: loop_dispatch_properties.sv
`timescale 1ns/10ps

module loop_dispatch_properties (
	input logic clk,
	input logic arst_n,
	input loop_pkg::core_vec_t gc_req,
	input loop_pkg::core_vec_t gc_grant,
	input logic busy,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready
);

	// Tally of failed assertions
	int fail_count = 0;

	grant_has_request: assert property (@(posedge clk) disable iff (!arst_n)
		(gc_grant & ~gc_req) == '0)
	else begin
		$error("grant to a core without a request");
		fail_count++;
	end

	grant_only_busy: assert property (@(posedge clk) disable iff (!arst_n)
		(gc_grant != '0) |-> busy)
	else begin
		$error("grant while the dispatcher is idle");
		fail_count++;
	end

	// Write response stays up until taken
	bvalid_holds: assert property (@(posedge clk) disable iff (!arst_n)
		bvalid && !bready |=> bvalid)
	else begin
		$error("bvalid dropped before bready");
		fail_count++;
	end

	rvalid_holds: assert property (@(posedge clk) disable iff (!arst_n)
		rvalid && !rready |=> rvalid)
	else begin
		$error("rvalid dropped before rready");
		fail_count++;
	end

endmodule

bind loop_dispatch_top loop_dispatch_properties loop_dispatch_properties_i (
	.clk(clk),
	.arst_n(arst_n),
	.gc_req(gc_req),
	.gc_grant(gc_grant),
	.busy(cfg_if.busy),
	.bvalid(bvalid),
	.bready(bready),
	.rvalid(rvalid),
	.rready(rready)
);

// File: loop_dispatch_tb.sv
`timescale 1ns/10ps

module loop_dispatch_tb;

	localparam int N_LOOP = 7;
	localparam int HS_LIMIT = 50;
	localparam int POLL_LIMIT = 200;

	logic clk;
	logic arst_n;
	loop_pkg::axi_addr_t awaddr;
	logic awvalid;
	logic awready;
	loop_pkg::axi_data_t wdata;
	loop_pkg::axi_strb_t wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	loop_pkg::axi_addr_t araddr;
	logic arvalid;
	logic arready;
	loop_pkg::axi_data_t rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	loop_pkg::core_vec_t gc_req;
	loop_pkg::core_vec_t core_idle;
	loop_pkg::core_vec_t gc_grant;
	loop_pkg::gc_t gc_out [loop_pkg::N_CORE];

	// Loop table columns
	loop_pkg::gc_t tbl_base [N_LOOP];
	loop_pkg::gd_t tbl_stride [N_LOOP];
	loop_pkg::cnt_t tbl_count [N_LOOP];
	int tbl_density [N_LOOP];
	logic tbl_restart [N_LOOP];

	// Reference model
	loop_pkg::gc_t expect_gc;
	loop_pkg::gd_t run_stride;
	int run_count;
	int run_issued;
	int last_grants;

	// Outstanding work per core in the core model
	int work [loop_pkg::N_CORE];
	int density;

	int errors;
	int checks;

	loop_dispatch_top loop_dispatch_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	function automatic int work_total();
		int sum;
		sum = 0;
		foreach (work[k]) begin
			sum += work[k];
		end
		return sum;
	endfunction

	task automatic add_loop_row(input int row, input loop_pkg::gc_t base, input loop_pkg::gd_t stride,
		input loop_pkg::cnt_t count, input int dens, input logic restart);
		tbl_base[row] = base;
		tbl_stride[row] = stride;
		tbl_count[row] = count;
		tbl_density[row] = dens;
		tbl_restart[row] = restart;
	endtask

	// Reference model walks the grants in core order
	always @(negedge clk) begin
		int n_this;
		logic gap;
		if (arst_n) begin
			n_this = 0;
			gap = 1'b0;
			for (int k = 0; k < loop_pkg::N_CORE; k++) begin
				if (gc_grant[k]) begin
					if (gap) begin
						report_failure($sformatf("core %0d granted ahead of a lower requester", k));
					end
					if (run_issued >= run_count) begin
						report_failure($sformatf("core %0d granted after the count was reached", k));
					end
					check_value($sformatf("gc_out[%0d]", k), gc_out[k], expect_gc);
					expect_gc = expect_gc + run_stride;
					run_issued++;
					n_this++;
					work[k] = work[k] + 1 + int'($urandom % 3);
				end else if (gc_req[k]) begin
					gap = 1'b1;
					// Mid-run every requester is served while iterations remain
					if (run_issued > 0 && run_issued < run_count) begin
						report_failure($sformatf("core %0d request not granted during the run", k));
					end
				end
			end
			last_grants = n_this;
		end
	end

	// Cores finish work at random and request by density
	always @(posedge clk) begin
		#2;
		if (arst_n) begin
			for (int k = 0; k < loop_pkg::N_CORE; k++) begin
				if (work[k] > 0 && ($urandom % 2) == 1) begin
					work[k]--;
				end
				gc_req[k] = int'($urandom % 100) < density;
				core_idle[k] = (work[k] == 0);
			end
		end
	end

	task automatic axi_write(input loop_pkg::axi_addr_t addr, input loop_pkg::axi_data_t data,
		input loop_pkg::axi_strb_t strb, output logic [1:0] resp);
		int t;
		@(posedge clk);
		#2;
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (!(awready && wready) && t < HS_LIMIT);
		if (!(awready && wready)) begin
			report_failure($sformatf("write to address %h was never accepted", addr));
		end
		@(posedge clk);
		#2;
		awvalid = 1'b0;
		wvalid = 1'b0;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (!bvalid && t < HS_LIMIT);
		if (!bvalid) begin
			report_failure($sformatf("write to address %h got no response", addr));
		end
		resp = bresp;
		@(posedge clk);
		#2;
		bready = 1'b1;
		@(posedge clk);
		#2;
		bready = 1'b0;
	endtask

	task automatic axi_read(input loop_pkg::axi_addr_t addr, output loop_pkg::axi_data_t data,
		output logic [1:0] resp, output int issued_before);
		int t;
		@(posedge clk);
		#2;
		araddr = addr;
		arvalid = 1'b1;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (!arready && t < HS_LIMIT);
		if (!arready) begin
			report_failure($sformatf("read of address %h was never accepted", addr));
		end
		@(posedge clk);
		// Grants of the acceptance cycle are not yet in REMAIN
		issued_before = run_issued - last_grants;
		#2;
		arvalid = 1'b0;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (!rvalid && t < HS_LIMIT);
		if (!rvalid) begin
			report_failure($sformatf("read of address %h got no data", addr));
		end
		data = rdata;
		resp = rresp;
		@(posedge clk);
		#2;
		rready = 1'b1;
		@(posedge clk);
		#2;
		rready = 1'b0;
	endtask

	task automatic read_expect(input loop_pkg::axi_addr_t addr, input loop_pkg::axi_data_t expected,
		input string name);
		loop_pkg::axi_data_t data;
		logic [1:0] resp;
		int snap;
		axi_read(addr, data, resp, snap);
		check_value(name, data, expected);
		check_value({name, " rresp"}, resp, loop_pkg::AXI_RESP_OKAY);
	endtask

	task automatic run_loop(input int i);
		loop_pkg::axi_data_t data;
		logic [1:0] resp;
		int snap;
		int polls;
		// Base goes in as two half words
		axi_write(loop_pkg::REG_BASE, tbl_base[i], 4'b0011, resp);
		axi_write(loop_pkg::REG_BASE, tbl_base[i], 4'b1100, resp);
		axi_write(loop_pkg::REG_STRIDE, tbl_stride[i], 4'hF, resp);
		axi_write(loop_pkg::REG_COUNT, {16'hDEAD, tbl_count[i]}, 4'hF, resp);
		read_expect(loop_pkg::REG_BASE, tbl_base[i], "BASE");
		read_expect(loop_pkg::REG_STRIDE, tbl_stride[i], "STRIDE");
		read_expect(loop_pkg::REG_COUNT, {16'h0, tbl_count[i]}, "COUNT");
		expect_gc = tbl_base[i];
		run_stride = tbl_stride[i];
		run_count = tbl_count[i];
		run_issued = 0;
		density = tbl_density[i];
		axi_write(loop_pkg::REG_CTRL, 32'h1, 4'h1, resp);
		check_value("bresp", resp, loop_pkg::AXI_RESP_OKAY);
		// Iterations still pending mean the run is live
		axi_read(loop_pkg::REG_STATUS, data, resp, snap);
		if (snap < run_count) begin
			check_value("STATUS", data, 32'h1);
		end else begin
			check_value("STATUS busy xor done", data[0] ^ data[1], 1'b1);
		end
		axi_read(loop_pkg::REG_REMAIN, data, resp, snap);
		check_value("REMAIN", data, tbl_count[i] - snap);
		if (tbl_restart[i]) begin
			axi_write(loop_pkg::REG_CTRL, 32'h1, 4'h1, resp);
			check_value("bresp", resp, loop_pkg::AXI_RESP_OKAY);
			axi_read(loop_pkg::REG_REMAIN, data, resp, snap);
			check_value("REMAIN", data, tbl_count[i] - snap);
		end
		polls = 0;
		do begin
			axi_read(loop_pkg::REG_STATUS, data, resp, snap);
			if (data[1]) begin
				check_value("outstanding work", work_total(), 0);
			end
			polls++;
		end while (!data[1] && polls < POLL_LIMIT);
		if (!data[1]) begin
			report_failure($sformatf("loop %0d never reported done", i));
		end
		check_value("STATUS", data, 32'h2);
		check_value("issued iterations", run_issued, tbl_count[i]);
		read_expect(loop_pkg::REG_STATUS, 32'h2, "STATUS");
		read_expect(loop_pkg::REG_REMAIN, 32'h0, "REMAIN");
	endtask

	initial begin
		loop_pkg::axi_data_t data;
		logic [1:0] resp;
		int snap;
		// Seed the generator once
		void'($urandom(32'h4882));
		errors = 0;
		checks = 0;
		arst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		gc_req = '0;
		core_idle = '1;
		density = 50;
		expect_gc = '0;
		run_stride = '0;
		run_count = 0;
		run_issued = 0;
		last_grants = 0;
		foreach (work[k]) begin
			work[k] = 0;
		end
		add_loop_row(0, 32'sd0, 32'sd1, 16'd16, 100, 1'b0);
		add_loop_row(1, 32'sd100, -32'sd3, 16'd13, 60, 1'b0);
		add_loop_row(2, -32'sd50, 32'sd7, 16'd0, 80, 1'b0);
		add_loop_row(3, 32'h7FFF_FFF0, 32'sd5, 16'd9, 30, 1'b0);
		add_loop_row(4, 32'sd1000, -32'sd1, 16'd60, 50, 1'b1);
		add_loop_row(5, 32'sd5, 32'sd0, 16'd1, 100, 1'b0);
		add_loop_row(6, -32'sd1, 32'sd2, 16'd37, 90, 1'b0);
		repeat (5) @(posedge clk);
		#2;
		arst_n = 1'b1;
		@(negedge clk);
		check_value("gc_grant", gc_grant, '0);
		check_value("awready", awready, 1'b0);
		check_value("wready", wready, 1'b0);
		check_value("arready", arready, 1'b0);
		check_value("bvalid", bvalid, 1'b0);
		check_value("rvalid", rvalid, 1'b0);
		read_expect(loop_pkg::REG_STATUS, 32'h0, "STATUS");

		// Partial strobes
		axi_write(loop_pkg::REG_BASE, 32'h1122_3344, 4'hF, resp);
		axi_write(loop_pkg::REG_BASE, 32'hAABB_CCDD, 4'b0101, resp);
		axi_write(loop_pkg::REG_STRIDE, 32'hFFFF_FFFD, 4'hF, resp);
		axi_write(loop_pkg::REG_COUNT, 32'h1234_ABCD, 4'b0010, resp);
		read_expect(loop_pkg::REG_BASE, 32'h11BB_33DD, "BASE");
		read_expect(loop_pkg::REG_COUNT, 32'h0000_AB00, "COUNT");

		// Unmapped addresses
		axi_write(5'h18, 32'hFFFF_FFFF, 4'hF, resp);
		check_value("bresp", resp, loop_pkg::AXI_RESP_SLVERR);
		axi_read(5'h1C, data, resp, snap);
		check_value("rresp", resp, loop_pkg::AXI_RESP_SLVERR);
		read_expect(loop_pkg::REG_BASE, 32'h11BB_33DD, "BASE");
		read_expect(loop_pkg::REG_STRIDE, 32'hFFFF_FFFD, "STRIDE");
		read_expect(loop_pkg::REG_COUNT, 32'h0000_AB00, "COUNT");

		for (int i = 0; i < N_LOOP; i++) begin
			run_loop(i);
		end

		$display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			loop_dispatch_top_i.loop_dispatch_properties_i.fail_count);
		if (errors == 0 && loop_dispatch_top_i.loop_dispatch_properties_i.fail_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: loop_dispatch_top.sv
`timescale 1ns/10ps

module loop_dispatch_top (
	input logic clk,
	input logic arst_n,

	// AXI4-Lite slave
	input loop_pkg::axi_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input loop_pkg::axi_data_t wdata,
	input loop_pkg::axi_strb_t wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input loop_pkg::axi_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output loop_pkg::axi_data_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,

	// Worker cores
	input loop_pkg::core_vec_t gc_req,
	input loop_pkg::core_vec_t core_idle,
	output loop_pkg::core_vec_t gc_grant,
	output loop_pkg::gc_t gc_out [loop_pkg::N_CORE]
);

	logic run;
	logic remain_zero;
	loop_pkg::grant_cnt_t grant_cnt;

	fork_cfg_if cfg_if ();

	axil_fork_regs axil_fork_regs_i (
		.clk,
		.arst_n,
		.awaddr,
		.awvalid,
		.awready,
		.wdata,
		.wstrb,
		.wvalid,
		.wready,
		.bresp,
		.bvalid,
		.bready,
		.araddr,
		.arvalid,
		.arready,
		.rdata,
		.rresp,
		.rvalid,
		.rready,
		.cfg(cfg_if.regs)
	);

	fork_ctrl_fsm fork_ctrl_fsm_i (
		.clk,
		.arst_n,
		.cfg(cfg_if.ctrl),
		.remain_zero,
		.core_idle,
		.run
	);

	iter_counter iter_counter_i (
		.clk,
		.arst_n,
		.cfg(cfg_if.cnt),
		.run,
		.grant_cnt,
		.remain_zero
	);

	// Remain comes straight off the interface
	gc_allocator gc_allocator_i (
		.clk,
		.arst_n,
		.cfg(cfg_if.alloc),
		.run,
		.remain_zero,
		.remain(cfg_if.remain),
		.gc_req,
		.gc_grant,
		.gc_out,
		.grant_cnt
	);

endmodule

// File: loop_pkg.sv
package loop_pkg;

	// Core count and datapath widths
	localparam int N_CORE = 4;
	localparam int GC_WIDTH = 32;
	localparam int CNT_WIDTH = 16;
	localparam int GRANT_WIDTH = $clog2(N_CORE + 1);

	// AXI4-Lite geometry
	localparam int AXI_ADDR_WIDTH = 5;
	localparam int AXI_DATA_WIDTH = 32;
	localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
	localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

	typedef logic signed [GC_WIDTH-1:0] gc_t;
	typedef logic signed [GC_WIDTH-1:0] gd_t;
	typedef logic [CNT_WIDTH-1:0] cnt_t;
	typedef logic [N_CORE-1:0] core_vec_t;
	typedef logic [GRANT_WIDTH-1:0] grant_cnt_t;
	typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
	typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;
	typedef logic [AXI_STRB_WIDTH-1:0] axi_strb_t;

	// Register map, byte offsets
	localparam axi_addr_t REG_CTRL = 5'h00;
	localparam axi_addr_t REG_STATUS = 5'h04;
	localparam axi_addr_t REG_BASE = 5'h08;
	localparam axi_addr_t REG_STRIDE = 5'h0C;
	localparam axi_addr_t REG_COUNT = 5'h10;
	localparam axi_addr_t REG_REMAIN = 5'h14;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DRAIN
	} fork_state_t;

endpackage

// File: verilog.f
loop_pkg.sv
fork_cfg_if.sv
axil_fork_regs.sv
fork_ctrl_fsm.sv
iter_counter.sv
gc_allocator.sv
loop_dispatch_top.sv
loop_dispatch_properties.sv
loop_dispatch_tb.sv
